/* rtl/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// address of the first fetch after reset
`define RV_RESET_PC 32'h8000_0000

// architectural registers, x0 included
`define RV_REG_COUNT 32

`endif

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;
  `include "rv_core_config.svh"

  typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    AUIPC  = 7'b001_0111,
    LUI    = 7'b011_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    SIZE_B  = 3'b000,
    SIZE_H  = 3'b001,
    SIZE_W  = 3'b010,
    SIZE_BU = 3'b100,
    SIZE_HU = 3'b101
  } mem_size_e;

  typedef enum logic [1:0] {BASE_RS1, BASE_PC, BASE_ZERO} base_sel_e;  // adder base
  typedef enum logic [1:0] {WB_SUM, WB_LINK, WB_LOAD} wb_sel_e;        // rd source

  typedef struct packed {
    reg_idx_t            rd;
    reg_idx_t            rs1;
    reg_idx_t            rs2;
    mem_size_e           size;
    logic [`RV_XLEN-1:0] imm;
    base_sel_e           base_sel;
    wb_sel_e             wb_sel;
    logic                reg_write;
    logic                is_load;
    logic                is_store;
    logic                is_jump;
    logic                is_halt;
  } decoded_instr_t;
endpackage

/* rtl/rv_bus_pkg.sv */
package rv_bus_pkg;
  `include "rv_core_config.svh"

  // master to slave, read address and read data ready
  typedef struct packed {
    logic                ar_valid;
    logic [`RV_XLEN-1:0] ar_addr;
    logic                r_ready;
  } axil_rd_req_t;

  typedef struct packed {
    logic                ar_ready;
    logic                r_valid;
    logic [`RV_XLEN-1:0] r_data;
  } axil_rd_rsp_t;

  // master to slave, write address, write data and response ready
  typedef struct packed {
    logic                  aw_valid;
    logic [`RV_XLEN-1:0]   aw_addr;
    logic                  w_valid;
    logic [`RV_XLEN-1:0]   w_data;
    logic [`RV_XLEN/8-1:0] w_strb;
    logic                  b_ready;
  } axil_wr_req_t;

  typedef struct packed {
    logic aw_ready;
    logic w_ready;
    logic b_valid;
  } axil_wr_rsp_t;
endpackage

/* rtl/rv_decoder.sv */
`timescale 1ns/1ns

module rv_decoder import rv_isa_pkg::*; (
  input  logic [31:0]    instr,
  output decoded_instr_t decoded
);
  opcode_e     opcode;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = opcode_e'(instr[6:0]);

  // sign-extended immediates, u already in the upper 20 bits
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    decoded          = '0;
    decoded.rd       = instr[11:7];
    decoded.rs1      = instr[19:15];
    decoded.rs2      = instr[24:20];
    decoded.size     = mem_size_e'(instr[14:12]);
    decoded.imm      = imm_i;
    decoded.base_sel = BASE_RS1;
    decoded.wb_sel   = WB_SUM;
    case (opcode)
      OP_IMM: decoded.reg_write = (instr[14:12] == 3'b000);  // addi only
      LUI: begin
        decoded.imm       = imm_u;
        decoded.base_sel  = BASE_ZERO;  // 0 + imm
        decoded.reg_write = 1'b1;
      end
      AUIPC: begin
        decoded.imm       = imm_u;
        decoded.base_sel  = BASE_PC;
        decoded.reg_write = 1'b1;
      end
      JAL: begin
        decoded.imm       = imm_j;
        decoded.base_sel  = BASE_PC;
        decoded.wb_sel    = WB_LINK;
        decoded.reg_write = 1'b1;
        decoded.is_jump   = 1'b1;
      end
      JALR: begin
        decoded.wb_sel    = WB_LINK;
        decoded.reg_write = 1'b1;
        decoded.is_jump   = 1'b1;
      end
      LOAD: begin
        decoded.wb_sel    = WB_LOAD;
        decoded.reg_write = 1'b1;
        decoded.is_load   = 1'b1;
      end
      STORE: begin
        decoded.imm      = imm_s;
        decoded.is_store = 1'b1;  // no rd
      end
      SYSTEM: decoded.is_halt = (instr[31:7] == 25'h000_2000);  // ebreak
      default: ;  // unsupported, retires as a nop
    endcase
  end
endmodule

/* rtl/rv_fetch_unit.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_fetch_unit import rv_bus_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                consume,
  input  logic                redirect,
  input  logic [`RV_XLEN-1:0] redirect_pc,
  output logic [`RV_XLEN-1:0] instr,
  output logic                instr_valid,
  output axil_rd_req_t        bus_req,
  input  axil_rd_rsp_t        bus_rsp
);
  logic [`RV_XLEN-1:0] fetch_addr;  // next word to request
  logic [`RV_XLEN-1:0] req_addr;    // word of the outstanding read
  logic                in_flight;
  logic                ar_sent;
  logic                drop;        // outstanding read belongs to an old path
  logic                cur_valid;
  logic                pf_valid;
  logic [`RV_XLEN-1:0] cur_instr;
  logic [`RV_XLEN-1:0] pf_instr;
  logic                issue;
  logic                r_hs;
  logic                land_pf;

  assign bus_req.ar_valid = in_flight && !ar_sent;
  assign bus_req.ar_addr  = req_addr;
  assign bus_req.r_ready  = in_flight && ar_sent;

  assign r_hs    = bus_req.r_ready && bus_rsp.r_valid;
  // one read at a time, and only with a free slot for its data
  assign issue   = !in_flight && !pf_valid && !redirect;
  assign land_pf = consume ? pf_valid : cur_valid;

  assign instr       = cur_instr;
  assign instr_valid = cur_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_addr <= `RV_RESET_PC;
      in_flight  <= 1'b0;
      ar_sent    <= 1'b0;
      drop       <= 1'b0;
      cur_valid  <= 1'b0;
      pf_valid   <= 1'b0;
    end else begin
      if (issue) begin
        in_flight  <= 1'b1;
        ar_sent    <= 1'b0;
        fetch_addr <= fetch_addr + `RV_XLEN'd4;
      end else if (bus_req.ar_valid && bus_rsp.ar_ready) begin
        ar_sent <= 1'b1;
      end
      if (r_hs) in_flight <= 1'b0;

      if (redirect) begin
        // flush both slots and throw away any read still out
        cur_valid  <= 1'b0;
        pf_valid   <= 1'b0;
        fetch_addr <= redirect_pc;
        drop       <= in_flight && !r_hs;
      end else begin
        if (consume) begin
          cur_valid <= pf_valid;
          pf_valid  <= 1'b0;
        end
        if (r_hs && !drop) begin
          if (land_pf) pf_valid <= 1'b1;
          else cur_valid <= 1'b1;
        end
        if (r_hs) drop <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) req_addr <= fetch_addr;
    if (consume) cur_instr <= pf_instr;
    if (r_hs) begin
      if (land_pf) pf_instr <= bus_rsp.r_data;
      else cur_instr <= bus_rsp.r_data;
    end
  end

  // stale data from before a jump must never show up as the target
  assert property (@(posedge clk) disable iff (reset) drop |-> !instr_valid);
endmodule

/* rtl/rv_lsu.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_lsu import rv_isa_pkg::*, rv_bus_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                is_store,
  input  mem_size_e           size,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] store_data,
  output logic                done,
  output logic [`RV_XLEN-1:0] load_data,
  output axil_rd_req_t        rd_req,
  input  axil_rd_rsp_t        rd_rsp,
  output axil_wr_req_t        wr_req,
  input  axil_wr_rsp_t        wr_pair
);
  typedef enum logic [1:0] {IDLE, READ, WRITE, RESP} lsu_state_e;

  lsu_state_e            state;
  logic                  addr_sent;  // ar or aw accepted
  logic                  data_sent;  // w accepted
  logic [`RV_XLEN-1:0]   word_addr;
  logic [1:0]            lane;
  mem_size_e             size_q;
  logic [`RV_XLEN-1:0]   wdata;
  logic [`RV_XLEN-1:0]   lanes_data;
  logic [`RV_XLEN/8-1:0] strb;
  logic [`RV_XLEN/8-1:0] strb_q;
  logic [`RV_XLEN-1:0]   shifted;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  r_hs;

  assign rd_req.ar_valid = (state == READ) && !addr_sent;
  assign rd_req.ar_addr  = word_addr;
  assign rd_req.r_ready  = (state == READ) && addr_sent;
  assign wr_req.aw_valid = (state == WRITE) && !addr_sent;
  assign wr_req.aw_addr  = word_addr;
  assign wr_req.w_valid  = (state == WRITE) && !data_sent;
  assign wr_req.w_data   = wdata;
  assign wr_req.w_strb   = strb_q;
  assign wr_req.b_ready  = (state == RESP);

  assign aw_hs = wr_req.aw_valid && wr_pair.aw_ready;
  assign w_hs  = wr_req.w_valid && wr_pair.w_ready;
  assign r_hs  = rd_req.r_ready && rd_rsp.r_valid;
  assign done  = r_hs || (wr_req.b_ready && wr_pair.b_valid);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      addr_sent <= 1'b0;
      data_sent <= 1'b0;
    end else begin
      case (state)
        IDLE: if (start) state <= is_store ? WRITE : READ;
        READ: begin
          if (rd_req.ar_valid && rd_rsp.ar_ready) addr_sent <= 1'b1;
          if (r_hs) begin
            state     <= IDLE;
            addr_sent <= 1'b0;
          end
        end
        WRITE: begin
          // aw and w may complete in either order
          if (aw_hs) addr_sent <= 1'b1;
          if (w_hs) data_sent <= 1'b1;
          if ((addr_sent || aw_hs) && (data_sent || w_hs)) begin
            state     <= RESP;
            addr_sent <= 1'b0;
            data_sent <= 1'b0;
          end
        end
        RESP: if (wr_pair.b_valid) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // store data repeated over every lane it may land in
  always_comb begin
    case (size)
      SIZE_B, SIZE_BU: begin
        lanes_data = {4{store_data[7:0]}};
        strb       = 4'b0001 << addr[1:0];
      end
      SIZE_H, SIZE_HU: begin
        lanes_data = {2{store_data[15:0]}};
        strb       = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        lanes_data = store_data;
        strb       = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (start) begin
      word_addr <= {addr[`RV_XLEN-1:2], 2'b00};
      lane      <= addr[1:0];
      size_q    <= size;
      wdata     <= lanes_data;
      strb_q    <= strb;
    end
  end

  assign shifted = rd_rsp.r_data >> {lane, 3'b000};  // addressed byte to lane 0

  always_comb begin
    case (size_q)
      SIZE_B:  load_data = {{24{shifted[7]}}, shifted[7:0]};
      SIZE_BU: load_data = {24'h00_0000, shifted[7:0]};
      SIZE_H:  load_data = {{16{shifted[15]}}, shifted[15:0]};
      SIZE_HU: load_data = {16'h0000, shifted[15:0]};
      default: load_data = rd_rsp.r_data;
    endcase
  end

  // halfwords on even bytes, words on word boundaries
  assert property (@(posedge clk) disable iff (reset)
    start |-> !((size inside {SIZE_H, SIZE_HU}) && addr[0]) &&
              !((size == SIZE_W) && (addr[1:0] != 2'b00)));
  // core holds off the next access until done
  assert property (@(posedge clk) disable iff (reset) start |-> state == IDLE);
endmodule

/* rtl/rv_bus_arbiter.sv */
`timescale 1ns/1ns

module rv_bus_arbiter import rv_bus_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  axil_rd_req_t fetch_req,
  output axil_rd_rsp_t fetch_rsp,
  input  axil_rd_req_t lsu_req,
  output axil_rd_rsp_t lsu_rsp,
  output axil_rd_req_t bus_req,
  input  axil_rd_rsp_t bus_rsp
);
  logic locked;     // owner held until its read data returns
  logic owner_lsu;
  logic grant_lsu;

  // lsu wins a tie, the grant then stays put so a waiting ar stays stable
  assign grant_lsu = locked ? owner_lsu : lsu_req.ar_valid;

  always_comb begin
    bus_req   = grant_lsu ? lsu_req : fetch_req;
    fetch_rsp = '0;
    lsu_rsp   = '0;
    if (grant_lsu) begin
      lsu_rsp = bus_rsp;
    end else begin
      fetch_rsp = bus_rsp;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      locked    <= 1'b0;
      owner_lsu <= 1'b0;
    end else if (!locked && bus_req.ar_valid) begin
      locked    <= 1'b1;
      owner_lsu <= grant_lsu;
    end else if (locked && bus_rsp.r_valid && bus_req.r_ready) begin
      locked <= 1'b0;
    end
  end

  // read data only ever comes back for a granted, outstanding address
  assert property (@(posedge clk) disable iff (reset) bus_rsp.r_valid |-> locked);
endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_core import rv_isa_pkg::*, rv_bus_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  output axil_rd_req_t rd_req,
  input  axil_rd_rsp_t rd_rsp,
  output axil_wr_req_t wr_req,
  input  axil_wr_rsp_t wr_rsp,
  output logic         halted
);
  typedef enum logic [1:0] {WAIT_INSTR, EXECUTE, MEM_WAIT, HALTED} core_state_e;

  core_state_e         state;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
  logic [`RV_XLEN-1:0] instr;
  logic                instr_valid;
  logic                consume;
  logic                redirect;
  logic [`RV_XLEN-1:0] redirect_pc;
  decoded_instr_t      dec;
  logic [`RV_XLEN-1:0] rs1_val;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] base;
  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] link;
  logic [`RV_XLEN-1:0] wb_data;
  logic [`RV_XLEN-1:0] load_data;
  logic                is_mem;
  logic                lsu_start;
  logic                lsu_done;
  axil_rd_req_t        fetch_rd_req;
  axil_rd_req_t        lsu_rd_req;
  axil_rd_rsp_t        fetch_rd_rsp;
  axil_rd_rsp_t        lsu_rd_rsp;

  rv_fetch_unit fetch_unit_inst (
    .clk(clk), .reset(reset),
    .consume(consume), .redirect(redirect), .redirect_pc(redirect_pc),
    .instr(instr), .instr_valid(instr_valid),
    .bus_req(fetch_rd_req), .bus_rsp(fetch_rd_rsp)
  );

  rv_decoder decoder_inst (.instr(instr), .decoded(dec));

  rv_lsu lsu_inst (
    .clk(clk), .reset(reset),
    .start(lsu_start), .is_store(dec.is_store), .size(dec.size),
    .addr(sum), .store_data(rs2_val),
    .done(lsu_done), .load_data(load_data),
    .rd_req(lsu_rd_req), .rd_rsp(lsu_rd_rsp),
    .wr_req(wr_req), .wr_pair(wr_rsp)
  );

  rv_bus_arbiter bus_arbiter_inst (
    .clk(clk), .reset(reset),
    .fetch_req(fetch_rd_req), .fetch_rsp(fetch_rd_rsp),
    .lsu_req(lsu_rd_req), .lsu_rsp(lsu_rd_rsp),
    .bus_req(rd_req), .bus_rsp(rd_rsp)
  );

  assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];  // x0 reads zero
  assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

  always_comb begin
    case (dec.base_sel)
      BASE_PC:   base = pc;
      BASE_ZERO: base = '0;
      default:   base = rs1_val;
    endcase
  end

  assign sum         = base + dec.imm;  // address, target and addi/lui/auipc result
  assign link        = pc + `RV_XLEN'd4;
  assign redirect_pc = {sum[`RV_XLEN-1:1], 1'b0};
  assign is_mem      = dec.is_load || dec.is_store;

  assign lsu_start = (state == EXECUTE) && is_mem;
  assign redirect  = (state == EXECUTE) && dec.is_jump;
  assign consume   = ((state == EXECUTE) && !is_mem && !dec.is_halt) ||
                     ((state == MEM_WAIT) && lsu_done);
  assign halted    = (state == HALTED);

  always_comb begin
    case (dec.wb_sel)
      WB_LINK: wb_data = link;
      WB_LOAD: wb_data = load_data;
      default: wb_data = sum;
    endcase
  end

  always_ff @(posedge clk) begin
    if (consume && dec.reg_write && (dec.rd != '0)) regs[dec.rd] <= wb_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= WAIT_INSTR;
      pc    <= `RV_RESET_PC;
    end else begin
      if (consume) pc <= redirect ? redirect_pc : link;
      case (state)
        WAIT_INSTR: if (instr_valid) state <= EXECUTE;
        EXECUTE: begin
          if (dec.is_halt) state <= HALTED;  // ebreak, nothing more is fetched
          else if (is_mem) state <= MEM_WAIT;
          else state <= WAIT_INSTR;
        end
        MEM_WAIT: if (lsu_done) state <= WAIT_INSTR;
        default: state <= HALTED;
      endcase
    end
  end

  // an instruction retires only while the fetch unit still presents it
  assert property (@(posedge clk) disable iff (reset) consume |-> instr_valid);
endmodule

/* dv/rv_mem_model.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_mem_model import rv_bus_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  axil_rd_req_t rd_req,
  output axil_rd_rsp_t rd_rsp,
  input  axil_wr_req_t wr_req,
  output axil_wr_rsp_t wr_rsp
);
  localparam int WORDS = 64;

  logic [31:0] mem [WORDS];  // word 0 sits at the reset pc
  integer      seed;
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [1:0]  b_wait;
  logic        rd_busy;      // address taken, data not yet returned
  logic [31:0] rd_addr;
  logic        aw_got;
  logic        w_got;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;

  function automatic logic in_range(input logic [31:0] a);
    return (a >= `RV_RESET_PC) && (a < `RV_RESET_PC + 4 * WORDS);
  endfunction

  initial begin
    seed   = 45715;
    rd_rsp = '0;
    wr_rsp = '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      rd_rsp  <= '0;
      rd_busy <= 1'b0;
      ar_wait <= 2'd0;
      r_wait  <= 2'd0;
    end else begin
      rd_rsp.ar_ready <= 1'b0;
      if (!rd_busy) begin
        if (rd_req.ar_valid) begin
          if (ar_wait == 2'd0) begin
            rd_rsp.ar_ready <= 1'b1;
            rd_busy         <= 1'b1;
            rd_addr         <= rd_req.ar_addr;
            r_wait          <= 2'($random(seed));
          end else ar_wait <= ar_wait - 2'd1;
        end
      end else if (!rd_rsp.ar_ready) begin
        if (rd_rsp.r_valid) begin
          if (rd_req.r_ready) begin
            rd_rsp.r_valid <= 1'b0;
            rd_busy        <= 1'b0;
            ar_wait        <= 2'($random(seed));
          end
        end else if (r_wait == 2'd0) begin
          rd_rsp.r_valid <= 1'b1;
          // outside the array the data is just the inverted address
          rd_rsp.r_data  <= in_range(rd_addr) ? mem[(rd_addr - `RV_RESET_PC) >> 2] : ~rd_addr;
        end else r_wait <= r_wait - 2'd1;
      end
    end
  end

  always @(posedge clk) begin : wr_side
    int b;
    if (reset) begin
      wr_rsp  <= '0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      aw_wait <= 2'd0;
      w_wait  <= 2'd0;
      b_wait  <= 2'd0;
    end else begin
      wr_rsp.aw_ready <= 1'b0;
      wr_rsp.w_ready  <= 1'b0;
      if (wr_req.aw_valid && !aw_got) begin
        if (aw_wait == 2'd0) begin
          wr_rsp.aw_ready <= 1'b1;
          aw_got          <= 1'b1;
          wr_addr         <= wr_req.aw_addr;
          aw_wait         <= 2'($random(seed));
        end else aw_wait <= aw_wait - 2'd1;
      end
      if (wr_req.w_valid && !w_got) begin
        if (w_wait == 2'd0) begin
          wr_rsp.w_ready <= 1'b1;
          w_got          <= 1'b1;
          wr_data        <= wr_req.w_data;
          wr_strb        <= wr_req.w_strb;
          w_wait         <= 2'($random(seed));
        end else w_wait <= w_wait - 2'd1;
      end
      if (aw_got && w_got && !wr_rsp.aw_ready && !wr_rsp.w_ready) begin
        if (wr_rsp.b_valid) begin
          if (wr_req.b_ready) begin
            wr_rsp.b_valid <= 1'b0;
            aw_got         <= 1'b0;
            w_got          <= 1'b0;
          end
        end else if (b_wait == 2'd0) begin
          wr_rsp.b_valid <= 1'b1;
          b_wait         <= 2'($random(seed));
          if (in_range(wr_addr)) begin
            for (b = 0; b < 4; b++) begin
              if (wr_strb[b]) mem[(wr_addr - `RV_RESET_PC) >> 2][8*b +: 8] <= wr_data[8*b +: 8];
            end
          end
        end else b_wait <= b_wait - 2'd1;
      end
    end
  end
endmodule

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_core_tb import rv_isa_pkg::*, rv_bus_pkg::*; ();
  localparam logic [31:0] BASE      = `RV_RESET_PC;
  localparam logic [31:0] POISON    = BASE + 32'h200;
  localparam logic [31:0] DATA_WORD = 32'h80F1_7F82;  // preloaded at base + 0xfc
  localparam logic [31:0] X3_VAL    = {20'h12345, 12'h000} + 32'h678;

  logic         clk;
  logic         reset;
  axil_rd_req_t rd_req;
  axil_rd_rsp_t rd_rsp;
  axil_wr_req_t wr_req;
  axil_wr_rsp_t wr_rsp;
  logic         halted;

  string       names [6] = '{"reset_fetch", "alu_results", "store_lanes",
                             "load_extend", "jump_link", "halt"};
  int          errors [6];
  logic        done_flag [6];
  int          stray_errors;
  logic [31:0] exp_addr [32];
  logic [31:0] exp_data [32];
  logic [3:0]  exp_strb [32];
  int          exp_test [32];
  logic        exp_last [32];  // final store of its test
  int          n_exp;
  int          st_idx;
  int          pc_idx;
  int          roff;           // next result slot, offset from x1
  int          cycles;
  int          halt_cycles;
  int          max_cycles;
  logic        first_ar;
  logic        rep_pend;
  int          rep_id;
  logic        w_hs;
  logic        ar_hs;

  rv_core rv_core_inst (
    .clk(clk), .reset(reset), .rd_req(rd_req), .rd_rsp(rd_rsp),
    .wr_req(wr_req), .wr_rsp(wr_rsp), .halted(halted)
  );

  rv_mem_model mem_model_inst (
    .clk(clk), .reset(reset), .rd_req(rd_req), .rd_rsp(rd_rsp),
    .wr_req(wr_req), .wr_rsp(wr_rsp)
  );

  always #10 clk = ~clk;

  assign w_hs  = wr_req.w_valid && wr_rsp.w_ready;
  assign ar_hs = rd_req.ar_valid && rd_rsp.ar_ready;

  function automatic logic [31:0] sext12(input logic [11:0] i);
    return {{20{i[11]}}, i};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd, input opcode_e op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], STORE};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), JAL};
  endfunction

  // lane select and extension of the preloaded word
  function automatic logic [31:0] load_value(input logic [2:0] f3, input int k);
    logic [7:0]  b;
    logic [15:0] h;
    b = DATA_WORD[8*k +: 8];
    h = DATA_WORD[8*(k & 2) +: 16];
    case (f3)
      3'b000:  return {{24{b[7]}}, b};
      3'b100:  return {24'h0, b};
      3'b001:  return {{16{h[15]}}, h};
      3'b101:  return {16'h0, h};
      default: return DATA_WORD;
    endcase
  endfunction

  task automatic put(input logic [31:0] w);
    mem_model_inst.mem[pc_idx] = w;
    pc_idx++;
  endtask

  task automatic expect_store(input int test, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
    exp_test[n_exp] = test;
    exp_addr[n_exp] = addr;
    exp_data[n_exp] = data;
    exp_strb[n_exp] = strb;
    n_exp++;
  endtask

  task automatic store_reg(input int rs2, input int test, input logic [31:0] value);
    put(enc_s(12'(roff), rs2, 1, SIZE_W));
    expect_store(test, BASE + roff, value, 4'hF);
    roff += 4;
  endtask

  task automatic load_check(input logic [2:0] f3, input int k);
    put(enc_i(12'(32'hFC + k), 1, f3, 6, LOAD));
    store_reg(6, 3, load_value(f3, k));
  endtask

  task automatic build_program();
    int          k;
    logic [31:0] pc;
    for (k = 0; k < 64; k++) mem_model_inst.mem[k] = (BASE + 4 * k) ^ 32'h5A5A_0000;
    mem_model_inst.mem[63] = DATA_WORD;
    put({20'h0, 5'd1, AUIPC});                 // x1 = base
    put({20'h12345, 5'd2, LUI});
    put(enc_i(12'h678, 2, 3'b000, 3, OP_IMM));
    put(enc_i(12'hFFB, 0, 3'b000, 4, OP_IMM));
    store_reg(1, 1, BASE + {20'h0, 12'h0});
    store_reg(2, 1, {20'h12345, 12'h000});
    store_reg(3, 1, {20'h12345, 12'h000} + sext12(12'h678));
    store_reg(4, 1, 32'h0 + sext12(12'hFFB));
    pc = BASE + 4 * pc_idx;                    // auipc away from the base
    put({20'h00001, 5'd5, AUIPC});
    store_reg(5, 1, pc + {20'h00001, 12'h000});
    for (k = 0; k < 4; k++) begin
      put(enc_s(12'(roff + k), 3, 1, SIZE_B));
      expect_store(2, BASE + roff, {4{X3_VAL[7:0]}}, 4'b0001 << k);
    end
    roff += 4;
    for (k = 0; k < 4; k += 2) begin
      put(enc_s(12'(roff + k), 3, 1, SIZE_H));
      expect_store(2, BASE + roff, {2{X3_VAL[15:0]}}, (k == 2) ? 4'b1100 : 4'b0011);
    end
    roff += 4;
    for (k = 0; k < 4; k++) load_check(SIZE_B, k);
    for (k = 0; k < 4; k++) load_check(SIZE_BU, k);
    for (k = 0; k < 4; k += 2) load_check(SIZE_H, k);
    for (k = 0; k < 4; k += 2) load_check(SIZE_HU, k);
    load_check(SIZE_W, 0);
    pc = BASE + 4 * pc_idx;
    put(enc_j(21'd12, 7));                     // over the poison store
    put(enc_s(12'h200, 0, 1, SIZE_W));
    put(enc_j(21'd12, 0));                     // jalr lands here
    store_reg(7, 4, pc + 4);
    put(enc_i(12'd5, 7, 3'b000, 8, JALR));     // bit 0 of the target cleared
    store_reg(8, 4, pc + 20);
    put(32'h0010_0073);                        // ebreak
    for (k = 0; k < n_exp; k++) exp_last[k] = (k == n_exp - 1) || (exp_test[k + 1] != exp_test[k]);
  endtask

  task automatic value_fail(input int id, input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s: expected %h, actual %h", names[id], exp, act);
    errors[id]++;
  endtask

  task automatic report_test(input int id);
    done_flag[id] = 1'b1;
    if (errors[id] == 0) $display("[PASS] %s", names[id]);
    else $display("%s finished with %0d errors", names[id], errors[id]);
  endtask

  task automatic finish_run();
    int i;
    int passed;
    int failed;
    passed = 0;
    failed = 0;
    report_test(5);
    for (i = 0; i < 6; i++) begin
      if (!done_flag[i]) $display("%s never reached its check", names[i]);
      if (done_flag[i] && errors[i] == 0) passed++;
      else failed++;
    end
    $display("tests passed %0d, failed %0d, unexpected stores %0d", passed, failed, stray_errors);
    if (failed == 0 && stray_errors == 0) $display("SIMULATION PASSED");
    else $display("SIMULATION FAILED");
    $finish;
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    pc_idx       = 0;
    n_exp        = 0;
    roff         = 32'h100;
    stray_errors = 0;
    foreach (errors[i]) errors[i] = 0;
    foreach (done_flag[i]) done_flag[i] = 1'b0;
    build_program();
    // up to 4 handshakes of 4 cycles per instruction, doubled for arbitration
    max_cycles = 2 + pc_idx * 32;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      st_idx   <= 0;
      first_ar <= 1'b0;
      rep_pend <= 1'b0;
    end else begin
      rep_pend <= 1'b0;
      if (rep_pend) report_test(rep_id);  // a cycle late so failing actions are counted
      if (ar_hs && !first_ar) begin
        first_ar <= 1'b1;
        rep_pend <= 1'b1;
        rep_id   <= 0;
      end
      if (w_hs && st_idx < n_exp) begin
        st_idx <= st_idx + 1;
        if (exp_last[st_idx]) begin
          rep_pend <= 1'b1;
          rep_id   <= exp_test[st_idx];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (halted) halt_cycles <= halt_cycles + 1;
    if (halt_cycles == 20) begin
      finish_run();
    end else if (cycles >= max_cycles && max_cycles > 0) begin
      $display("timeout after %0d cycles, the core never halted", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    cycles      = 0;
    halt_cycles = 0;
  end

  assert property (@(posedge clk) disable iff (reset)
    ar_hs && !first_ar |-> rd_req.ar_addr == `RV_RESET_PC)
    else value_fail(0, `RV_RESET_PC, $sampled(rd_req.ar_addr));

  assert property (@(posedge clk) disable iff (reset) w_hs |-> st_idx < n_exp)
    else begin
      $display("store to %h came after the last expected store", $sampled(wr_req.aw_addr));
      stray_errors++;
    end

  assert property (@(posedge clk) disable iff (reset)
    w_hs && st_idx < n_exp |-> wr_req.w_data == exp_data[st_idx])
    else value_fail(exp_test[$sampled(st_idx)], exp_data[$sampled(st_idx)],
                    $sampled(wr_req.w_data));

  assert property (@(posedge clk) disable iff (reset)
    w_hs && st_idx < n_exp |-> wr_req.w_strb == exp_strb[st_idx])
    else value_fail(exp_test[$sampled(st_idx)], 32'(exp_strb[$sampled(st_idx)]),
                    32'($sampled(wr_req.w_strb)));

  assert property (@(posedge clk) disable iff (reset)
    w_hs && st_idx < n_exp |-> wr_req.aw_addr == exp_addr[st_idx])
    else value_fail(exp_test[$sampled(st_idx)], exp_addr[$sampled(st_idx)],
                    $sampled(wr_req.aw_addr));

  assert property (@(posedge clk) disable iff (reset) w_hs |-> wr_req.aw_addr != POISON)
    else begin
      $display("jump_link: the skipped store wrote the poison address");
      errors[4]++;
    end

  // halted only after every store of the program went out
  assert property (@(posedge clk) disable iff (reset) $rose(halted) |-> st_idx == n_exp)
    else value_fail(5, 32'(n_exp), 32'($sampled(st_idx)));

  assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else value_fail(5, 32'd1, 32'd0);

  assert property (@(posedge clk) disable iff (reset)
    halted |-> !$rose(rd_req.ar_valid) && !$rose(wr_req.aw_valid))
    else begin
      $display("halt: a new read or write address was issued after ebreak");
      errors[5]++;
    end
endmodule

/* verilog.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_bus_pkg.sv
rtl/rv_decoder.sv
rtl/rv_fetch_unit.sv
rtl/rv_lsu.sv
rtl/rv_bus_arbiter.sv
rtl/rv_core.sv
dv/rv_mem_model.sv
dv/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/rv_isa_pkg.sv
      - rtl/rv_bus_pkg.sv
      - rtl/rv_decoder.sv
      - rtl/rv_fetch_unit.sv
      - rtl/rv_lsu.sv
      - rtl/rv_bus_arbiter.sv
      - rtl/rv_core.sv
  - target: simulation
    files:
      - dv/rv_mem_model.sv
      - dv/rv_core_tb.sv
